//--- hw/rs_pkg.sv
// Shared definitions for the reservation station cluster
// Widths, ALU op encoding, operand union, entry, issue and result structs
// ALU reference function shared by the ALU and the testbench model

package rs_pkg;

	// ==============================
	// Widths
	// ==============================
	localparam int TAG_W  = 6;
	localparam int DATA_W = 32;

	// ALU operations
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLL = 3'd5
	} alu_op_t;

	// ==============================
	// Operand encoding
	// ==============================
	// Waiting view of an operand word, tag in the low bits
	typedef struct packed {
		logic [DATA_W-TAG_W-1:0] pad;
		logic [TAG_W-1:0]        tag;
	} operand_wait_t;

	// Same word read as a value or as the tag being waited for
	typedef union packed {
		logic [DATA_W-1:0] value;
		operand_wait_t     waiting;
	} operand_body_u;

	// Valid set means body holds the value, clear means body holds the tag
	typedef struct packed {
		logic          valid;
		operand_body_u body;
	} operand_t;

	// One station slot
	typedef struct packed {
		logic             busy;
		alu_op_t          op;
		logic [TAG_W-1:0] dst_tag;
		operand_t         src_a;
		operand_t         src_b;
	} rs_entry_t;

	// Issued op with both operands resolved
	typedef struct packed {
		alu_op_t           op;
		logic [TAG_W-1:0]  dst_tag;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} issue_t;

	// Result broadcast
	typedef struct packed {
		logic              valid;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
	} result_t;

	// ALU behaviour, shift amount from low 5 bits of b
	function automatic logic [DATA_W-1:0] alu_compute(
		input alu_op_t           op,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		logic [DATA_W-1:0] res;
		case (op)
			ADD:     res = a + b;
			SUB:     res = a - b;
			AND:     res = a & b;
			OR:      res = a | b;
			XOR:     res = a ^ b;
			SLL:     res = a << b[4:0];
			default: res = '0;
		endcase
		return res;
	endfunction

endpackage

//--- hw/operand_capture.sv
// Operand wakeup comparator
// Matches a waiting tag against every broadcast bus and captures the value
`timescale 1ns/1ps

module operand_capture #(
	parameter int NBYP = 2
) (
	input  rs_pkg::operand_t             oper_i,
	input  rs_pkg::result_t [NBYP-1:0]   bus_i,
	output rs_pkg::operand_t             oper_o
);
	import rs_pkg::*;

	// Tag view of the incoming word
	logic [TAG_W-1:0] want_tag;

	always_comb begin
		oper_o   = oper_i;
		want_tag = oper_i.body.waiting.tag;
		// Valid operands pass unchanged
		if (!oper_i.valid) begin
			for (int i = 0; i < NBYP; i++) begin
				// Only one bus should carry a given tag in a cycle
				if (bus_i[i].valid && (bus_i[i].tag == want_tag)) begin
					oper_o.valid      = 1'b1;
					oper_o.body.value = bus_i[i].value;
				end
			end
		end
	end

endmodule

//--- hw/ready_select.sv
// Issue picker
// Lowest index entry that is busy with both operands valid
`timescale 1ns/1ps

module ready_select #(
	parameter int NRSE = 4,
	localparam int SEL_W = $clog2(NRSE)
) (
	input  rs_pkg::rs_entry_t [NRSE-1:0] entries_i,
	output logic                         any_o,
	output logic [SEL_W-1:0]             sel_o
);

	logic [NRSE-1:0] ready;

	always_comb begin
		// Per entry ready flags
		for (int i = 0; i < NRSE; i++) begin
			ready[i] = entries_i[i].busy && entries_i[i].src_a.valid &&
				entries_i[i].src_b.valid;
		end

		// Priority encode, scan from the top so the lowest index wins
		any_o = 1'b0;
		sel_o = '0;
		for (int i = NRSE - 1; i >= 0; i--) begin
			if (ready[i]) begin
				any_o = 1'b1;
				sel_o = SEL_W'(i);
			end
		end

		// Picked slot must really be ready in the stored entries
		if (any_o) begin
			assert (entries_i[sel_o].busy && entries_i[sel_o].src_a.valid &&
				entries_i[sel_o].src_b.valid)
				else $error("ready_select picked entry %0d which is not ready", sel_o);
		end
	end

endmodule

//--- hw/reservation_station.sv
// Reservation station
// Entry storage, dispatch into the lowest free slot, operand wakeup
// Issue of the lowest ready slot into a registered issue port under stall
`timescale 1ns/1ps

module reservation_station #(
	parameter int NRSE = 4,
	parameter int NBYP = 2
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       disp_valid_i,
	input  rs_pkg::rs_entry_t          disp_entry_i,
	output logic                       disp_ready_o,
	input  rs_pkg::result_t [NBYP-1:0] bus_i,
	input  logic                       stall_i,
	output logic                       issue_valid_o,
	output rs_pkg::issue_t             issue_o
);
	import rs_pkg::*;

	localparam int SEL_W = $clog2(NRSE);

	rs_entry_t [NRSE-1:0] entries;
	operand_t  [NRSE-1:0] cap_a;
	operand_t  [NRSE-1:0] cap_b;
	operand_t             in_a;
	operand_t             in_b;
	rs_entry_t            disp_new;
	logic [NRSE-1:0]      busy_vec;
	logic [SEL_W-1:0]     free_idx;
	logic [SEL_W-1:0]     sel_idx;
	logic                 any_free;
	logic                 any_ready;
	logic                 disp_fire;
	logic                 issue_fire;

	// ==============================
	// Wakeup
	// ==============================
	// Two comparators per stored slot
	for (genvar g = 0; g < NRSE; g++) begin : g_slot
		operand_capture #(.NBYP(NBYP)) u_cap_a (
			.oper_i (entries[g].src_a),
			.bus_i  (bus_i),
			.oper_o (cap_a[g])
		);
		operand_capture #(.NBYP(NBYP)) u_cap_b (
			.oper_i (entries[g].src_b),
			.bus_i  (bus_i),
			.oper_o (cap_b[g])
		);
		assign busy_vec[g] = entries[g].busy;
	end

	// Incoming op also sees this cycle's broadcasts
	operand_capture #(.NBYP(NBYP)) u_in_a (
		.oper_i (disp_entry_i.src_a),
		.bus_i  (bus_i),
		.oper_o (in_a)
	);
	operand_capture #(.NBYP(NBYP)) u_in_b (
		.oper_i (disp_entry_i.src_b),
		.bus_i  (bus_i),
		.oper_o (in_b)
	);

	// ==============================
	// Select and allocate
	// ==============================
	ready_select #(.NRSE(NRSE)) u_sel (
		.entries_i (entries),
		.any_o     (any_ready),
		.sel_o     (sel_idx)
	);

	// Lowest free slot
	always_comb begin
		any_free = 1'b0;
		free_idx = '0;
		for (int i = NRSE - 1; i >= 0; i--) begin
			if (!busy_vec[i]) begin
				any_free = 1'b1;
				free_idx = SEL_W'(i);
			end
		end
	end

	assign disp_ready_o = any_free;
	assign disp_fire    = disp_valid_i && any_free;
	assign issue_fire   = any_ready && !stall_i;

	// Busy bit forced, operands already woken
	always_comb begin
		disp_new       = disp_entry_i;
		disp_new.busy  = 1'b1;
		disp_new.src_a = in_a;
		disp_new.src_b = in_b;
	end

	// ==============================
	// State update
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NRSE; i++) begin
				entries[i].busy <= 1'b0;
			end
			issue_valid_o <= 1'b0;
		end else begin
			// Wakeup keeps running during stall
			for (int i = 0; i < NRSE; i++) begin
				entries[i].src_a <= cap_a[i];
				entries[i].src_b <= cap_b[i];
			end
			// Free the issued slot
			if (issue_fire) begin
				entries[sel_idx].busy <= 1'b0;
			end
			// Free slot is never the issuing one, no conflict
			if (disp_fire) begin
				entries[free_idx] <= disp_new;
			end
			issue_valid_o <= issue_fire;
		end
	end

	// Issue payload
	always_ff @(posedge clk) begin
		if (issue_fire) begin
			issue_o.op      <= entries[sel_idx].op;
			issue_o.dst_tag <= entries[sel_idx].dst_tag;
			issue_o.a       <= entries[sel_idx].src_a.body.value;
			issue_o.b       <= entries[sel_idx].src_b.body.value;
		end
	end

	// ==============================
	// Assertions
	// ==============================
	// Every accepted dispatch fills a slot that was free
	a_no_disp_full: assert property (@(posedge clk) disable iff (rst)
		disp_fire |=> ($countones(busy_vec) ==
			$countones($past(busy_vec)) + 1 - int'($past(issue_fire))));

	// Issue came from an occupied slot
	a_issue_busy: assert property (@(posedge clk) disable iff (rst)
		issue_valid_o |-> $past(busy_vec[sel_idx]));

	// Nothing issues out of a stalled cycle
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		issue_valid_o |-> !$past(stall_i));

endmodule

//--- hw/alu_unit.sv
// Single cycle integer ALU
// Registers the computed value with the destination tag of the issued op
`timescale 1ns/1ps

module alu_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            issue_valid_i,
	input  rs_pkg::issue_t  issue_i,
	output rs_pkg::result_t result_o
);
	import rs_pkg::*;

	logic              valid_q;
	logic [TAG_W-1:0]  tag_q;
	logic [DATA_W-1:0] value_q;

	// Valid follows issue by one edge
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue_valid_i;
		end
	end

	// Result word and tag, loaded only on issue
	always_ff @(posedge clk) begin
		if (issue_valid_i) begin
			tag_q   <= issue_i.dst_tag;
			value_q <= alu_compute(issue_i.op, issue_i.a, issue_i.b);
		end
	end

	assign result_o.valid = valid_q;
	assign result_o.tag   = tag_q;
	assign result_o.value = value_q;

	// Every result traces back to an issue
	a_result_src: assert property (@(posedge clk) disable iff (rst)
		result_o.valid |-> $past(issue_valid_i));

endmodule

//--- hw/rs_cluster_top.sv
// Issue cluster top
// Reservation station feeding one ALU, ALU result looped back as a broadcast
`timescale 1ns/1ps

module rs_cluster_top #(
	parameter int NRSE = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              disp_valid_i,
	input  rs_pkg::rs_entry_t disp_entry_i,
	output logic              disp_ready_o,
	input  rs_pkg::result_t   wb_i,
	input  logic              stall_i,
	output rs_pkg::result_t   result_o
);
	import rs_pkg::*;

	// ALU at index 0, external writeback at index 1
	localparam int NBYP = 2;

	result_t [NBYP-1:0] bcast;
	result_t            alu_result;
	issue_t             issue_q;
	logic               issue_valid;

	assign bcast[0] = alu_result;
	assign bcast[1] = wb_i;
	assign result_o = alu_result;

	reservation_station #(.NRSE(NRSE), .NBYP(NBYP)) u_rs (
		.clk           (clk),
		.rst           (rst),
		.disp_valid_i  (disp_valid_i),
		.disp_entry_i  (disp_entry_i),
		.disp_ready_o  (disp_ready_o),
		.bus_i         (bcast),
		.stall_i       (stall_i),
		.issue_valid_o (issue_valid),
		.issue_o       (issue_q)
	);

	alu_unit u_alu (
		.clk           (clk),
		.rst           (rst),
		.issue_valid_i (issue_valid),
		.issue_i       (issue_q),
		.result_o      (alu_result)
	);

endmodule

//--- bench/rs_tb.sv
// Testbench for the reservation station cluster
// Clock, reset, xorshift source, value check, watchdog and result monitor
// Directed tests for dispatch, wakeup, chains, full station, stall, random mix
`timescale 1ns/1ps

module rs_tb;
	import rs_pkg::*;

	// ==============================
	// Run limits
	// ==============================
	localparam int RAND_OPS   = 20;
	localparam int NUM_OPS    = 6 + 1 + 3 + 4 + 3 + RAND_OPS;
	localparam int CYC_PER_OP = 20;
	localparam int SLACK_CYC  = 50;

	logic    clk;
	logic    rst;
	logic    disp_valid_i;
	rs_entry_t disp_entry_i;
	logic    disp_ready_o;
	result_t wb_i;
	logic    stall_i;
	result_t result_o;

	// Expected results indexed by destination tag
	logic              exp_valid [2**TAG_W];
	logic [DATA_W-1:0] exp_value [2**TAG_W];
	int                outstanding;
	int                errors;
	logic [31:0]       rng_state;

	rs_cluster_top #(.NRSE(4)) dut_i (
		.clk          (clk),
		.rst          (rst),
		.disp_valid_i (disp_valid_i),
		.disp_entry_i (disp_entry_i),
		.disp_ready_o (disp_ready_o),
		.wb_i         (wb_i),
		.stall_i      (stall_i),
		.result_o     (result_o)
	);

	always #20 clk = ~clk;

	// Watchdog, bound from op count
	initial begin
		#((NUM_OPS * CYC_PER_OP + SLACK_CYC) * 40);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got,
				expected);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_run(input string what);
		errors++;
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "run aborted");
	endtask

	// Result monitor, registered output so negedge sampling is safe
	always @(negedge clk) begin
		if (!rst && result_o.valid) begin
			if (!exp_valid[result_o.tag]) begin
				fail_run($sformatf("Result with tag %0d arrived but none was expected",
					result_o.tag));
			end
			check_value("result_o.value", result_o.value, exp_value[result_o.tag]);
			exp_valid[result_o.tag] = 1'b0;
			outstanding--;
		end
	end

	function automatic operand_t make_oper(input logic waits, input logic [TAG_W-1:0] tag,
		input logic [DATA_W-1:0] val);
		operand_t o;
		o = '0;
		o.valid = !waits;
		if (waits) begin
			o.body.waiting.tag = tag;
		end else begin
			o.body.value = val;
		end
		return o;
	endfunction

	// Hands one op to the station, returns at the negedge after the transfer
	task automatic dispatch(input alu_op_t op, input logic [TAG_W-1:0] dst,
		input operand_t oa, input operand_t ob,
		input logic [DATA_W-1:0] a_val, input logic [DATA_W-1:0] b_val);
		while (!disp_ready_o) @(negedge clk);
		exp_valid[dst] = 1'b1;
		exp_value[dst] = alu_compute(op, a_val, b_val);
		outstanding++;
		disp_entry_i         = '0;
		disp_entry_i.op      = op;
		disp_entry_i.dst_tag = dst;
		disp_entry_i.src_a   = oa;
		disp_entry_i.src_b   = ob;
		disp_valid_i         = 1'b1;
		@(negedge clk);
		disp_valid_i = 1'b0;
	endtask

	// One cycle external writeback
	task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] val);
		wb_i = '{valid: 1'b1, tag: tag, value: val};
		@(negedge clk);
		wb_i = '0;
	endtask

	task automatic wait_all();
		while (outstanding != 0) @(negedge clk);
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic ready_dispatch();
		alu_op_t op;
		for (int i = 0; i < 6; i++) begin
			op = alu_op_t'(3'(i));
			dispatch(op, TAG_W'(i), make_oper(1'b0, '0, 32'h1234_0000 + 32'(i * 77)),
				make_oper(1'b0, '0, 32'h0000_0013 + 32'(i)),
				32'h1234_0000 + 32'(i * 77), 32'h0000_0013 + 32'(i));
			check_value("result_o.valid", 32'(result_o.valid), 32'd0);
			@(negedge clk);
			check_value("result_o.valid", 32'(result_o.valid), 32'd0);
			// Two edges after dispatch
			@(negedge clk);
			check_value("result_o.valid", 32'(result_o.valid), 32'd1);
			check_value("result_o.tag", 32'(result_o.tag), 32'(i));
		end
		wait_all();
	endtask

	task automatic external_wakeup();
		dispatch(SUB, 6'd6, make_oper(1'b0, '0, 32'd5000), make_oper(1'b1, 6'd40, '0),
			32'd5000, 32'd1234);
		repeat (5) @(negedge clk);
		check_value("outstanding results", 32'(outstanding), 32'd1);
		broadcast(6'd40, 32'd1234);
		wait_all();
	endtask

	task automatic dependency_chain();
		logic [DATA_W-1:0] r1;
		logic [DATA_W-1:0] r2;
		r1 = alu_compute(ADD, 32'd100, 32'd23);
		r2 = alu_compute(SUB, r1, 32'd7);
		dispatch(ADD, 6'd20, make_oper(1'b0, '0, 32'd100), make_oper(1'b0, '0, 32'd23),
			32'd100, 32'd23);
		dispatch(SUB, 6'd21, make_oper(1'b1, 6'd20, '0), make_oper(1'b0, '0, 32'd7),
			r1, 32'd7);
		dispatch(SLL, 6'd22, make_oper(1'b1, 6'd21, '0), make_oper(1'b0, '0, 32'd3),
			r2, 32'd3);
		wait_all();
	endtask

	task automatic full_station();
		for (int i = 0; i < 4; i++) begin
			dispatch(XOR, TAG_W'(30 + i), make_oper(1'b0, '0, 32'hA5A5_0000 + 32'(i)),
				make_oper(1'b1, TAG_W'(40 + i), '0),
				32'hA5A5_0000 + 32'(i), 32'h0F0F_0F00 + 32'(i));
		end
		check_value("disp_ready_o", 32'(disp_ready_o), 32'd0);
		for (int i = 0; i < 4; i++) begin
			broadcast(TAG_W'(40 + i), 32'h0F0F_0F00 + 32'(i));
		end
		wait_all();
		check_value("disp_ready_o", 32'(disp_ready_o), 32'd1);
	endtask

	task automatic stall_release();
		stall_i = 1'b1;
		dispatch(OR, 6'd34, make_oper(1'b0, '0, 32'hF000_0000), make_oper(1'b0, '0, 32'h11),
			32'hF000_0000, 32'h11);
		dispatch(AND, 6'd35, make_oper(1'b0, '0, 32'hFFFF_00FF),
			make_oper(1'b0, '0, 32'h0F0F_0F0F), 32'hFFFF_00FF, 32'h0F0F_0F0F);
		dispatch(ADD, 6'd36, make_oper(1'b0, '0, 32'hFFFF_FFFF), make_oper(1'b0, '0, 32'd2),
			32'hFFFF_FFFF, 32'd2);
		repeat (4) @(negedge clk);
		// Held entries produce nothing
		check_value("outstanding results", 32'(outstanding), 32'd3);
		stall_i = 1'b0;
		wait_all();
	endtask

	task automatic random_mix();
		logic [TAG_W-1:0]  wtags [$];
		logic [DATA_W-1:0] wvals [$];
		alu_op_t           op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic              waits;
		logic [TAG_W-1:0]  wt;
		int                nwait;
		nwait = 0;
		for (int i = 0; i < RAND_OPS; i++) begin
			op    = alu_op_t'(3'(next_rand() % 6));
			a     = next_rand();
			b     = next_rand();
			waits = (next_rand() % 4) == 0;
			wt    = TAG_W'(48 + (nwait % 16));
			dispatch(op, TAG_W'(8 + i), make_oper(1'b0, '0, a), make_oper(waits, wt, b), a, b);
			if (waits) begin
				wtags.push_back(wt);
				wvals.push_back(b);
				nwait++;
			end
			// Keep at most one waiting op pending between dispatches
			if (wtags.size() >= 2) begin
				broadcast(wtags.pop_front(), wvals.pop_front());
			end
		end
		while (wtags.size() > 0) begin
			broadcast(wtags.pop_front(), wvals.pop_front());
		end
		wait_all();
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		disp_valid_i = 1'b0;
		disp_entry_i = '0;
		wb_i         = '0;
		stall_i      = 1'b0;
		outstanding  = 0;
		errors       = 0;
		rng_state    = 32'hbd334b7b;
		for (int t = 0; t < 2**TAG_W; t++) begin
			exp_valid[t] = 1'b0;
			exp_value[t] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("disp_ready_o", 32'(disp_ready_o), 32'd1);
		check_value("result_o.valid", 32'(result_o.valid), 32'd0);
		ready_dispatch();
		external_wakeup();
		dependency_chain();
		full_station();
		stall_release();
		random_mix();
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- resv_station.f
hw/rs_pkg.sv
hw/operand_capture.sv
hw/ready_select.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/rs_cluster_top.sv
bench/rs_tb.sv

//--- Makefile
# Verilator build and run of the reservation station cluster testbench

SIM      ?= verilator
TOP      ?= rs_tb
FILELIST ?= resv_station.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), pass when the pass message is seen"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "  help   list these targets"
	@echo "Variables: SIM TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
